//--- lcd_pkg.sv
`default_nettype none

package lcd_pkg;

    typedef logic [7:0] lcd_byte_t;  // command or data byte on the bus
    typedef logic [6:0] lcd_addr_t;  // DDRAM address

    // command kinds, the first INIT_COUNT in init order
    typedef enum logic [2:0] {
        KIND_FUNCTION_SET = 3'd0,
        KIND_DISPLAY_ON   = 3'd1,
        KIND_CLEAR        = 3'd2,
        KIND_ENTRY_MODE   = 3'd3,
        KIND_HOME_ADDR    = 3'd4,
        KIND_SET_ADDR     = 3'd5
    } lcd_cmd_t;

    localparam int unsigned INIT_COUNT = 5;

    localparam lcd_byte_t CMD_FUNCTION_SET  = 8'h38;  // 8-bit bus, 2 lines, 5x8 font
    localparam lcd_byte_t CMD_DISPLAY_ON    = 8'h0c;  // no cursor, no blink
    localparam lcd_byte_t CMD_CLEAR         = 8'h01;
    localparam lcd_byte_t CMD_ENTRY_MODE    = 8'h06;  // increment, no shift
    localparam lcd_byte_t CMD_SET_ADDR_BASE = 8'h80;  // address goes in the low 7 bits

    localparam lcd_addr_t LINE0_ADDR = 7'd0;
    localparam lcd_addr_t LINE1_ADDR = 7'd64;

    typedef enum logic [2:0] {
        S_BEGIN,
        S_INIT,
        S_IDLE,
        S_SET_ADDRESS,
        S_WRITE
    } ctrl_state_t;

    // phases of one bus cycle, shared by both units
    typedef enum logic [1:0] {
        PH_IDLE,
        PH_SETUP,
        PH_EN,
        PH_WAIT
    } bus_phase_t;

endpackage

`default_nettype wire

//--- lcd_text_pkg.sv
`default_nettype none

package lcd_text_pkg;

    typedef logic [7:0] char_t;        // CGROM code
    typedef logic [2:0] mode_t;
    typedef logic [4:0] screen_pos_t;  // 0..15 row one, 16..31 row two

    localparam char_t       CH_SPACE     = 8'h20;
    localparam int unsigned SCREEN_CHARS = 32;

    localparam mode_t MODE_INIT         = 3'd0;
    localparam mode_t MODE_STOP         = 3'd1;
    localparam mode_t MODE_PLAY_PAUSE   = 3'd2;
    localparam mode_t MODE_RECORD_PAUSE = 3'd3;
    localparam mode_t MODE_PLAYING      = 3'd4;
    localparam mode_t MODE_RECORDING    = 3'd5;

    // text sits from column MSG_COL to the end of row one
    localparam int unsigned MSG_COL = 3;
    localparam int unsigned MSG_LEN = 13;

    typedef logic [8*MSG_LEN-1:0] msg_t;  // first character in the top byte

    localparam msg_t MSG_INIT         = "Initializing ";
    localparam msg_t MSG_STOP         = "Stop         ";
    localparam msg_t MSG_PLAY_PAUSE   = "Play Pause   ";
    localparam msg_t MSG_RECORD_PAUSE = "Record Pause ";
    localparam msg_t MSG_PLAYING      = "Playing      ";
    localparam msg_t MSG_RECORDING    = "Recording    ";

endpackage

`default_nettype wire

//--- lcd_text_rom.sv
`timescale 1ns/100ps
`default_nettype none

module lcd_text_rom (
    input  wire lcd_text_pkg::mode_t       i_mode,
    input  wire lcd_text_pkg::screen_pos_t i_pos,
    output lcd_text_pkg::char_t            o_char
);
    import lcd_text_pkg::*;

    msg_t        msg;
    int unsigned slot;  // byte slot in msg, counted from the low end

    always_comb begin
        case (i_mode)
            MODE_INIT:         msg = MSG_INIT;
            MODE_STOP:         msg = MSG_STOP;
            MODE_PLAY_PAUSE:   msg = MSG_PLAY_PAUSE;
            MODE_RECORD_PAUSE: msg = MSG_RECORD_PAUSE;
            MODE_PLAYING:      msg = MSG_PLAYING;
            default:           msg = MSG_RECORDING;  // 5..7
        endcase
    end

    always_comb begin
        slot   = MSG_COL + MSG_LEN - 1 - int'(i_pos);
        o_char = CH_SPACE;
        // row two and the left margin stay blank
        if (i_pos >= MSG_COL && i_pos < MSG_COL + MSG_LEN)
            o_char = msg[8*slot +: 8];
    end

endmodule

`default_nettype wire

//--- lcd_instruction_unit.sv
`timescale 1ns/100ps
`default_nettype none

module lcd_instruction_unit #(
    parameter int unsigned SETUP_CYCLES      = 2,
    parameter int unsigned EN_HIGH_CYCLES    = 12,
    parameter int unsigned CMD_WAIT_CYCLES   = 2000,
    parameter int unsigned CLEAR_WAIT_CYCLES = 82000
) (
    input  wire                     i_clk,
    input  wire                     i_rst_n,
    input  wire                     i_req,
    input  wire lcd_pkg::lcd_cmd_t  i_cmd,
    input  wire lcd_pkg::lcd_addr_t i_addr,
    output lcd_pkg::lcd_byte_t      o_lcd_data,
    output logic                    o_lcd_en,
    output logic                    o_lcd_rs,
    output logic                    o_lcd_rw,
    output logic                    o_finish
);
    import lcd_pkg::*;

    localparam int unsigned MAX_A   = SETUP_CYCLES > EN_HIGH_CYCLES ?
                                      SETUP_CYCLES : EN_HIGH_CYCLES;
    localparam int unsigned MAX_B   = CMD_WAIT_CYCLES > CLEAR_WAIT_CYCLES ?
                                      CMD_WAIT_CYCLES : CLEAR_WAIT_CYCLES;
    localparam int unsigned MAX_CYC = MAX_A > MAX_B ? MAX_A : MAX_B;
    localparam int unsigned CNT_W   = $clog2(MAX_CYC + 1);

    bus_phase_t       phase_r;
    logic [CNT_W-1:0] cnt_r;
    logic [CNT_W-1:0] wait_last;
    logic             clear_r;
    logic             en_r;
    logic             finish_r;
    lcd_byte_t        data_r;

    function automatic lcd_byte_t encode(lcd_cmd_t cmd, lcd_addr_t addr);
        case (cmd)
            KIND_FUNCTION_SET: encode = CMD_FUNCTION_SET;
            KIND_DISPLAY_ON:   encode = CMD_DISPLAY_ON;
            KIND_CLEAR:        encode = CMD_CLEAR;
            KIND_ENTRY_MODE:   encode = CMD_ENTRY_MODE;
            KIND_HOME_ADDR:    encode = CMD_SET_ADDR_BASE | {1'b0, LINE0_ADDR};
            default:           encode = CMD_SET_ADDR_BASE | {1'b0, addr};
        endcase
    endfunction

    // clear needs the long settle
    assign wait_last = clear_r ? CNT_W'(CLEAR_WAIT_CYCLES - 1) : CNT_W'(CMD_WAIT_CYCLES - 1);

    always_ff @(posedge i_clk) begin
        if (i_req && phase_r == PH_IDLE)
            data_r <= encode(i_cmd, i_addr);
    end

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            phase_r  <= PH_IDLE;
            cnt_r    <= '0;
            clear_r  <= 1'b0;
            en_r     <= 1'b0;
            finish_r <= 1'b0;
        end else begin
            finish_r <= 1'b0;
            case (phase_r)
                PH_IDLE: if (i_req) begin
                    phase_r <= PH_SETUP;
                    cnt_r   <= '0;
                    clear_r <= (i_cmd == KIND_CLEAR);
                end
                PH_SETUP: if (cnt_r == CNT_W'(SETUP_CYCLES - 1)) begin
                    phase_r <= PH_EN;
                    cnt_r   <= '0;
                    en_r    <= 1'b1;
                end else begin
                    cnt_r <= cnt_r + 1'b1;
                end
                PH_EN: if (cnt_r == CNT_W'(EN_HIGH_CYCLES - 1)) begin
                    phase_r <= PH_WAIT;
                    cnt_r   <= '0;
                    en_r    <= 1'b0;  // panel latches here
                end else begin
                    cnt_r <= cnt_r + 1'b1;
                end
                PH_WAIT: if (cnt_r == wait_last) begin
                    phase_r  <= PH_IDLE;
                    finish_r <= 1'b1;
                end else begin
                    cnt_r <= cnt_r + 1'b1;
                end
                default: phase_r <= PH_IDLE;
            endcase
        end
    end

    assign o_lcd_data = data_r;
    assign o_lcd_en   = en_r;
    assign o_lcd_rs   = 1'b0;  // command register
    assign o_lcd_rw   = 1'b0;
    assign o_finish   = finish_r;

    a_en_width: assert property (@(posedge i_clk) disable iff (i_rst_n)
        $rose(o_lcd_en) |-> o_lcd_en [*EN_HIGH_CYCLES] ##1 !o_lcd_en)
        else $error("instruction EN pulse width wrong");

endmodule

`default_nettype wire

//--- lcd_write_unit.sv
`timescale 1ns/100ps
`default_nettype none

module lcd_write_unit #(
    parameter int unsigned SETUP_CYCLES    = 2,
    parameter int unsigned EN_HIGH_CYCLES  = 12,
    parameter int unsigned CMD_WAIT_CYCLES = 2000
) (
    input  wire                      i_clk,
    input  wire                      i_rst_n,
    input  wire                      i_req,
    input  wire lcd_text_pkg::char_t i_char,
    output lcd_pkg::lcd_byte_t       o_lcd_data,
    output logic                     o_lcd_en,
    output logic                     o_lcd_rs,
    output logic                     o_lcd_rw,
    output logic                     o_finish
);
    import lcd_pkg::*;

    localparam int unsigned MAX_A   = SETUP_CYCLES > EN_HIGH_CYCLES ?
                                      SETUP_CYCLES : EN_HIGH_CYCLES;
    localparam int unsigned MAX_CYC = MAX_A > CMD_WAIT_CYCLES ? MAX_A : CMD_WAIT_CYCLES;
    localparam int unsigned CNT_W   = $clog2(MAX_CYC + 1);

    bus_phase_t       phase_r;
    logic [CNT_W-1:0] cnt_r;
    logic             rs_r;
    logic             en_r;
    logic             finish_r;
    lcd_byte_t        data_r;

    always_ff @(posedge i_clk) begin
        if (i_req && phase_r == PH_IDLE)
            data_r <= i_char;
    end

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            phase_r  <= PH_IDLE;
            cnt_r    <= '0;
            rs_r     <= 1'b0;
            en_r     <= 1'b0;
            finish_r <= 1'b0;
        end else begin
            finish_r <= 1'b0;
            case (phase_r)
                PH_IDLE: if (i_req) begin
                    phase_r <= PH_SETUP;
                    cnt_r   <= '0;
                    rs_r    <= 1'b1;  // data register from now on
                end
                PH_SETUP: if (cnt_r == CNT_W'(SETUP_CYCLES - 1)) begin
                    phase_r <= PH_EN;
                    cnt_r   <= '0;
                    en_r    <= 1'b1;
                end else begin
                    cnt_r <= cnt_r + 1'b1;
                end
                PH_EN: if (cnt_r == CNT_W'(EN_HIGH_CYCLES - 1)) begin
                    phase_r <= PH_WAIT;
                    cnt_r   <= '0;
                    en_r    <= 1'b0;
                end else begin
                    cnt_r <= cnt_r + 1'b1;
                end
                PH_WAIT: if (cnt_r == CNT_W'(CMD_WAIT_CYCLES - 1)) begin
                    phase_r  <= PH_IDLE;
                    finish_r <= 1'b1;
                end else begin
                    cnt_r <= cnt_r + 1'b1;
                end
                default: phase_r <= PH_IDLE;
            endcase
        end
    end

    assign o_lcd_data = data_r;
    assign o_lcd_en   = en_r;
    assign o_lcd_rs   = rs_r;
    assign o_lcd_rw   = 1'b0;
    assign o_finish   = finish_r;

endmodule

`default_nettype wire

//--- lcd_controller.sv
`timescale 1ns/100ps
`default_nettype none

module lcd_controller #(
    parameter int unsigned EN_HIGH_CYCLES    = 12,
    parameter int unsigned SETUP_CYCLES      = 2,
    parameter int unsigned CMD_WAIT_CYCLES   = 2000,
    parameter int unsigned CLEAR_WAIT_CYCLES = 82000
) (
    input  wire                       i_clk,
    input  wire                       i_rst_n,
    input  wire                       i_start,
    input  wire lcd_text_pkg::mode_t  i_mode,
    input  wire lcd_text_pkg::char_t  i_char,
    output lcd_text_pkg::mode_t       o_mode,
    output lcd_text_pkg::screen_pos_t o_pos,
    output lcd_pkg::lcd_byte_t        o_lcd_data,
    output logic                      o_lcd_en,
    output logic                      o_lcd_rs,
    output logic                      o_lcd_rw,
    output logic                      o_init_done,
    output logic                      o_render_done
);
    import lcd_pkg::*;
    import lcd_text_pkg::*;

    localparam screen_pos_t LAST_POS = screen_pos_t'(SCREEN_CHARS - 1);
    localparam screen_pos_t ROW_END  = screen_pos_t'(SCREEN_CHARS / 2 - 1);

    ctrl_state_t state_r;
    logic [2:0]  index_r;  // init command index
    lcd_cmd_t    cmd_r;
    lcd_addr_t   addr_r;
    logic        inst_req_r;
    logic        write_req_r;
    screen_pos_t pos_r;
    mode_t       mode_r;
    logic        start_d;
    logic        init_done_r;
    logic        render_done_r;
    logic        start_edge;
    logic        sel_inst;

    lcd_byte_t   inst_data;
    logic        inst_en, inst_rs, inst_rw, inst_finish;
    lcd_byte_t   wr_data;
    logic        wr_en, wr_rs, wr_rw, wr_finish;

    lcd_instruction_unit #(
        .SETUP_CYCLES      (SETUP_CYCLES),
        .EN_HIGH_CYCLES    (EN_HIGH_CYCLES),
        .CMD_WAIT_CYCLES   (CMD_WAIT_CYCLES),
        .CLEAR_WAIT_CYCLES (CLEAR_WAIT_CYCLES)
    ) u_inst (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_req      (inst_req_r),
        .i_cmd      (cmd_r),
        .i_addr     (addr_r),
        .o_lcd_data (inst_data),
        .o_lcd_en   (inst_en),
        .o_lcd_rs   (inst_rs),
        .o_lcd_rw   (inst_rw),
        .o_finish   (inst_finish)
    );

    lcd_write_unit #(
        .SETUP_CYCLES    (SETUP_CYCLES),
        .EN_HIGH_CYCLES  (EN_HIGH_CYCLES),
        .CMD_WAIT_CYCLES (CMD_WAIT_CYCLES)
    ) u_write (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_req      (write_req_r),
        .i_char     (i_char),
        .o_lcd_data (wr_data),
        .o_lcd_en   (wr_en),
        .o_lcd_rs   (wr_rs),
        .o_lcd_rw   (wr_rw),
        .o_finish   (wr_finish)
    );

    assign start_edge = i_start && !start_d;
    assign sel_inst   = (state_r == S_INIT) || (state_r == S_SET_ADDRESS);

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            state_r       <= S_BEGIN;
            index_r       <= '0;
            cmd_r         <= KIND_FUNCTION_SET;
            addr_r        <= LINE0_ADDR;
            inst_req_r    <= 1'b0;
            write_req_r   <= 1'b0;
            pos_r         <= '0;
            mode_r        <= MODE_INIT;
            start_d       <= 1'b0;
            init_done_r   <= 1'b0;
            render_done_r <= 1'b0;
        end else begin
            inst_req_r  <= 1'b0;
            write_req_r <= 1'b0;
            start_d     <= i_start;
            case (state_r)
                S_BEGIN: begin
                    cmd_r      <= KIND_FUNCTION_SET;
                    index_r    <= '0;
                    inst_req_r <= 1'b1;
                    state_r    <= S_INIT;
                end
                S_INIT: if (inst_finish) begin
                    if (index_r == 3'(INIT_COUNT - 1)) begin
                        state_r     <= S_IDLE;
                        init_done_r <= 1'b1;
                    end else begin
                        index_r    <= index_r + 3'd1;
                        cmd_r      <= lcd_cmd_t'(index_r + 3'd1);  // kinds follow init order
                        inst_req_r <= 1'b1;
                    end
                end
                S_IDLE: if (start_edge) begin
                    mode_r        <= i_mode;  // held for the whole render
                    pos_r         <= '0;
                    cmd_r         <= KIND_SET_ADDR;
                    addr_r        <= LINE0_ADDR;
                    inst_req_r    <= 1'b1;
                    render_done_r <= 1'b0;
                    state_r       <= S_SET_ADDRESS;
                end
                S_SET_ADDRESS: if (inst_finish) begin
                    write_req_r <= 1'b1;
                    state_r     <= S_WRITE;
                end
                S_WRITE: if (wr_finish) begin
                    if (pos_r == LAST_POS) begin
                        render_done_r <= 1'b1;
                        state_r       <= S_IDLE;
                    end else begin
                        pos_r <= pos_r + 1'b1;
                        if (pos_r == ROW_END) begin  // jump to row two
                            cmd_r      <= KIND_SET_ADDR;
                            addr_r     <= LINE1_ADDR;
                            inst_req_r <= 1'b1;
                            state_r    <= S_SET_ADDRESS;
                        end else begin
                            write_req_r <= 1'b1;
                        end
                    end
                end
                default: state_r <= S_BEGIN;
            endcase
        end
    end

    // pins follow whichever unit the state owns
    assign o_lcd_data    = sel_inst ? inst_data : wr_data;
    assign o_lcd_en      = sel_inst ? inst_en : wr_en;
    assign o_lcd_rs      = sel_inst ? inst_rs : wr_rs;
    assign o_lcd_rw      = sel_inst ? inst_rw : wr_rw;
    assign o_mode        = mode_r;
    assign o_pos         = pos_r;
    assign o_init_done   = init_done_r;
    assign o_render_done = render_done_r;

    // no request to either unit until the running one finishes
    a_inst_excl: assert property (@(posedge i_clk) disable iff (i_rst_n)
        inst_req_r |=> (!inst_req_r && !write_req_r) throughout inst_finish [->1])
        else $error("request while instruction unit busy");
    a_write_excl: assert property (@(posedge i_clk) disable iff (i_rst_n)
        write_req_r |=> (!inst_req_r && !write_req_r) throughout wr_finish [->1])
        else $error("request while write unit busy");

endmodule

`default_nettype wire

//--- lcd_display_top.sv
`timescale 1ns/100ps
`default_nettype none

module lcd_display_top #(
    parameter int unsigned EN_HIGH_CYCLES    = 12,
    parameter int unsigned SETUP_CYCLES      = 2,
    parameter int unsigned CMD_WAIT_CYCLES   = 2000,   // about 40 us at 50 MHz
    parameter int unsigned CLEAR_WAIT_CYCLES = 82000   // about 1.64 ms
) (
    input  wire                      i_clk,
    input  wire                      i_rst_n,
    input  wire                      i_start,
    input  wire lcd_text_pkg::mode_t i_mode,
    output lcd_pkg::lcd_byte_t       o_lcd_data,
    output logic                     o_lcd_en,
    output logic                     o_lcd_rs,
    output logic                     o_lcd_rw,
    output logic                     o_init_done,
    output logic                     o_render_done
);
    import lcd_text_pkg::*;

    mode_t       mode;
    screen_pos_t pos;
    char_t       char_code;

    lcd_controller #(
        .EN_HIGH_CYCLES    (EN_HIGH_CYCLES),
        .SETUP_CYCLES      (SETUP_CYCLES),
        .CMD_WAIT_CYCLES   (CMD_WAIT_CYCLES),
        .CLEAR_WAIT_CYCLES (CLEAR_WAIT_CYCLES)
    ) u_ctrl (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_start       (i_start),
        .i_mode        (i_mode),
        .i_char        (char_code),
        .o_mode        (mode),
        .o_pos         (pos),
        .o_lcd_data    (o_lcd_data),
        .o_lcd_en      (o_lcd_en),
        .o_lcd_rs      (o_lcd_rs),
        .o_lcd_rw      (o_lcd_rw),
        .o_init_done   (o_init_done),
        .o_render_done (o_render_done)
    );

    lcd_text_rom u_rom (
        .i_mode (mode),
        .i_pos  (pos),
        .o_char (char_code)
    );

endmodule

`default_nettype wire

//--- lcd_panel_model.sv
`timescale 1ns/100ps
`default_nettype none

module lcd_panel_model (
    input wire                     i_rst_n,
    input wire lcd_pkg::lcd_byte_t i_data,
    input wire                     i_en,
    input wire                     i_rs
);
    import lcd_pkg::*;

    localparam int unsigned LOG_DEPTH = 1024;

    lcd_byte_t   cmd_log [LOG_DEPTH];
    lcd_byte_t   ddram [128];
    int unsigned cmd_count;
    int unsigned write_count;
    lcd_addr_t   cursor;

    initial begin
        cmd_count   = 0;
        write_count = 0;
        cursor      = '0;
        // junk that differs per address, so stale cells show up
        for (int a = 0; a < 128; a++) begin
            ddram[a] = 8'(a) ^ 8'hc5;
        end
    end

    // the panel latches on the falling edge of EN
    always @(negedge i_en) begin
        if (!i_rst_n) begin  // reset is active high
            if (!i_rs) begin
                if (cmd_count < LOG_DEPTH)
                    cmd_log[cmd_count] = i_data;
                cmd_count++;
                if (i_data[7]) begin
                    cursor = i_data[6:0];  // set DDRAM address
                end else if (i_data == CMD_CLEAR) begin
                    for (int a = 0; a < 128; a++) begin
                        ddram[a] = 8'h20;
                    end
                    cursor = '0;
                end
            end else begin
                ddram[cursor] = i_data;
                cursor        = cursor + 7'd1;
                write_count++;
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_lcd_display.sv
`timescale 1ns/100ps
`default_nettype none

module tb_lcd_display;
    import lcd_pkg::*;
    import lcd_text_pkg::*;

    localparam int unsigned EN_HIGH        = 3;
    localparam int unsigned SETUP          = 2;
    localparam int unsigned CMD_WAIT       = 4;
    localparam int unsigned CLEAR_WAIT     = 10;
    localparam int unsigned TIMEOUT_CYCLES = 5000;
    localparam int unsigned QUIET_CYCLES   = 60;  // window to see a stray render

    logic        clk;
    logic        rst_n;
    logic        start;
    mode_t       mode;
    lcd_byte_t   lcd_data;
    logic        lcd_en;
    logic        lcd_rs;
    logic        lcd_rw;
    logic        init_done;
    logic        render_done;
    int unsigned en_len;

    lcd_display_top #(
        .EN_HIGH_CYCLES    (EN_HIGH),
        .SETUP_CYCLES      (SETUP),
        .CMD_WAIT_CYCLES   (CMD_WAIT),
        .CLEAR_WAIT_CYCLES (CLEAR_WAIT)
    ) lcd_display_top_i (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_start       (start),
        .i_mode        (mode),
        .o_lcd_data    (lcd_data),
        .o_lcd_en      (lcd_en),
        .o_lcd_rs      (lcd_rs),
        .o_lcd_rw      (lcd_rw),
        .o_init_done   (init_done),
        .o_render_done (render_done)
    );

    lcd_panel_model panel (
        .i_rst_n (rst_n),
        .i_data  (lcd_data),
        .i_en    (lcd_en),
        .i_rs    (lcd_rs)
    );

    always #20 clk = ~clk;

    // screen text per mode, row one from column 3, rest blank
    function automatic char_t expected_char(input mode_t m, input int pos);
        string text;
        int    col;
        case (m)
            3'd0:    text = "Initializing";
            3'd1:    text = "Stop";
            3'd2:    text = "Play Pause";
            3'd3:    text = "Record Pause";
            3'd4:    text = "Playing";
            default: text = "Recording";
        endcase
        col = pos - 3;
        if (pos < 16 && col >= 0 && col < text.len())
            return char_t'(text[col]);
        return 8'h20;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_byte(input lcd_byte_t actual, input lcd_byte_t expected,
                              input string what);
        if (actual !== expected)
            stop_on_error($sformatf("Error at %0t ns: %s is %02h, expected %02h",
                                    $time, what, actual, expected));
    endtask

    task automatic check_char(input char_t actual, input char_t expected, input string what);
        if (actual !== expected)
            stop_on_error($sformatf("Error at %0t ns: %s is %02h, expected %02h",
                                    $time, what, actual, expected));
    endtask

    task automatic check_count(input int unsigned actual, input int unsigned expected,
                               input string what);
        if (actual != expected)
            stop_on_error($sformatf("Error at %0t ns: %s is %0d, expected %0d",
                                    $time, what, actual, expected));
    endtask

    task automatic check_bit(input logic actual, input logic expected, input string what);
        if (actual !== expected)
            stop_on_error($sformatf("Error at %0t ns: %s is %b, expected %b",
                                    $time, what, actual, expected));
    endtask

    task automatic wait_init_done();
        int unsigned n;
        n = 0;
        @(negedge clk);
        while (init_done !== 1'b1) begin
            if (n == TIMEOUT_CYCLES)
                stop_on_error("Timed out waiting for the init sequence to finish");
            n++;
            @(negedge clk);
        end
    endtask

    task automatic wait_render_level(input logic level);
        int unsigned n;
        n = 0;
        @(negedge clk);
        while (render_done !== level) begin
            if (n == TIMEOUT_CYCLES)
                stop_on_error($sformatf("Timed out waiting for render done to be %b", level));
            n++;
            @(negedge clk);
        end
    endtask

    task automatic wait_writes(input int unsigned count);
        int unsigned n;
        n = 0;
        @(negedge clk);
        while (panel.write_count < count) begin
            if (n == TIMEOUT_CYCLES)
                stop_on_error("Timed out waiting for data writes to the panel");
            n++;
            @(negedge clk);
        end
    endtask

    task automatic pulse_start(input mode_t m);
        @(posedge clk);
        start <= 1'b1;
        mode  <= m;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic check_screen(input mode_t m);
        lcd_addr_t addr;
        for (int pos = 0; pos < 32; pos++) begin
            if (pos < 16)
                addr = LINE0_ADDR + lcd_addr_t'(pos);
            else
                addr = LINE1_ADDR + lcd_addr_t'(pos - 16);
            check_char(panel.ddram[addr], expected_char(m, pos),
                       $sformatf("mode %0d cell %0d", m, pos));
        end
    endtask

    // one render = two address commands and 32 writes
    task automatic check_render(input mode_t m, input int unsigned cmd_base,
                                input int unsigned wr_base);
        check_count(panel.cmd_count - cmd_base, 2, "commands in render");
        check_byte(panel.cmd_log[cmd_base], CMD_SET_ADDR_BASE | lcd_byte_t'(LINE0_ADDR),
                   "row one address command");
        check_byte(panel.cmd_log[cmd_base + 1], CMD_SET_ADDR_BASE | lcd_byte_t'(LINE1_ADDR),
                   "row two address command");
        check_count(panel.write_count - wr_base, 32, "data writes in render");
        check_screen(m);
    endtask

    task automatic check_quiet(input int unsigned cmd_count, input int unsigned wr_count);
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            check_bit(render_done, 1'b1, "render done while idle");
            check_count(panel.cmd_count, cmd_count, "command count while idle");
            check_count(panel.write_count, wr_count, "write count while idle");
        end
    endtask

    task automatic render_and_check(input mode_t m);
        int unsigned cmd_base;
        int unsigned wr_base;
        cmd_base = panel.cmd_count;
        wr_base  = panel.write_count;
        pulse_start(m);
        wait_render_level(1'b0);
        wait_render_level(1'b1);
        check_render(m, cmd_base, wr_base);
    endtask

    // rw and EN width, checked all the time
    always @(negedge clk) begin
        if (!rst_n) begin
            check_bit(lcd_rw, 1'b0, "lcd rw");
            if (lcd_en) begin
                en_len++;
            end else if (en_len != 0) begin
                check_count(en_len, EN_HIGH, "EN high cycles");
                en_len = 0;
            end
        end
    end

    initial begin
        int unsigned cmd_base;
        int unsigned wr_base;
        void'($urandom(39892));
        clk    = 1'b0;
        rst_n  = 1'b1;  // active high
        start  = 1'b0;
        mode   = '0;
        en_len = 0;

        repeat (4) @(posedge clk);
        @(negedge clk);
        check_bit(lcd_en, 1'b0, "lcd en in reset");
        check_bit(lcd_rs, 1'b0, "lcd rs in reset");
        check_bit(lcd_rw, 1'b0, "lcd rw in reset");
        check_bit(init_done, 1'b0, "init done in reset");
        check_bit(render_done, 1'b0, "render done in reset");
        @(posedge clk);
        rst_n <= 1'b0;

        // init commands
        wait_init_done();
        check_count(panel.cmd_count, 5, "init command count");
        check_byte(panel.cmd_log[0], CMD_FUNCTION_SET, "init command 0");
        check_byte(panel.cmd_log[1], CMD_DISPLAY_ON, "init command 1");
        check_byte(panel.cmd_log[2], CMD_CLEAR, "init command 2");
        check_byte(panel.cmd_log[3], CMD_ENTRY_MODE, "init command 3");
        check_byte(panel.cmd_log[4], CMD_SET_ADDR_BASE | lcd_byte_t'(LINE0_ADDR),
                   "init command 4");
        check_count(panel.write_count, 0, "writes during init");

        for (int m = 0; m < 8; m++) begin
            render_and_check(mode_t'(m));
        end

        // start held high renders once
        cmd_base = panel.cmd_count;
        wr_base  = panel.write_count;
        @(posedge clk);
        start <= 1'b1;
        mode  <= 3'd2;
        wait_render_level(1'b0);
        wait_render_level(1'b1);
        check_render(3'd2, cmd_base, wr_base);
        check_quiet(panel.cmd_count, panel.write_count);
        @(posedge clk);
        start <= 1'b0;
        check_quiet(panel.cmd_count, panel.write_count);

        // second pulse mid render is dropped, mode was latched
        cmd_base = panel.cmd_count;
        wr_base  = panel.write_count;
        pulse_start(3'd1);
        wait_render_level(1'b0);
        wait_writes(wr_base + 5);
        pulse_start(3'd4);
        wait_render_level(1'b1);
        check_render(3'd1, cmd_base, wr_base);
        check_quiet(panel.cmd_count, panel.write_count);

        repeat (6) begin
            render_and_check(mode_t'($urandom_range(7, 0)));
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
lcd_pkg.sv
lcd_text_pkg.sv
lcd_text_rom.sv
lcd_instruction_unit.sv
lcd_write_unit.sv
lcd_controller.sv
lcd_display_top.sv
lcd_panel_model.sv
tb_lcd_display.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module tb_lcd_display -o sim_lcd

# the pipe keeps a failing run from stopping the script before the search
./obj_dir/sim_lcd 2>&1 | tee sim.log

if grep -q "Done: errors found" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation passed"
